/* byte_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

// synchronous byte fifo, head entry shown on rdata without a read cycle
module byte_fifo #(
    parameter int FIFO_DEPTH = 16  // power of two
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  dbg_proto_pkg::dbg_byte_t wdata,
    input  logic                     pop,
    output dbg_proto_pkg::dbg_byte_t rdata,
    output logic                     full,
    output logic                     empty
);

    import dbg_proto_pkg::*;

    localparam int addr_w = $clog2(FIFO_DEPTH);

    dbg_byte_t         mem [FIFO_DEPTH];
    logic [addr_w:0]   wr_ptr;  // extra msb tells a full buffer from an empty one
    logic [addr_w:0]   rd_ptr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage array
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr[addr_w-1:0]] <= wdata;
    end

    assign rdata = mem[rd_ptr[addr_w-1:0]];

    // same slot, different lap means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

endmodule

`default_nettype wire

/* dbg_bus_pkg.sv */
`default_nettype none

// types of the cpu memory side
package dbg_bus_pkg;

    typedef logic [15:0] cpu_addr_t;   // 64 KB byte address space
    typedef logic [7:0]  cpu_data_t;   // byte wide data bus

    // number of data bytes carried by one packet
    typedef logic [15:0] xfer_count_t;

endpackage

`default_nettype wire

/* dbg_cmd_engine.sv */
`timescale 1ns/10ps
`default_nettype none

// decodes debug packets from the rx fifo, runs them and queues the responses
module dbg_cmd_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     brk,       // cpu side break request
    input  dbg_proto_pkg::dbg_byte_t rx_byte,
    input  logic                     rx_empty,
    output logic                     rx_pop,
    output dbg_proto_pkg::dbg_byte_t tx_byte,
    input  logic                     tx_full,
    output logic                     tx_push,
    output logic                     active,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output dbg_bus_pkg::cpu_addr_t   wb_adr,
    output dbg_bus_pkg::cpu_data_t   wb_wdata,
    input  dbg_bus_pkg::cpu_data_t   wb_rdata,
    input  logic                     wb_ack
);

    import dbg_proto_pkg::*;
    import dbg_bus_pkg::*;

    typedef enum logic [2:0] {
        st_disabled,
        st_decode,
        st_header,  // collects addr and count bytes
        st_echo,
        st_write,
        st_read
    } state_t;

    state_t      state_q, state_d;
    state_t      exec_q, exec_d;        // stage entered once the header is in
    logic [1:0]  hdr_cnt_q, hdr_cnt_d;  // 0 addr_lo, 1 addr_hi, 2 cnt_lo, 3 cnt_hi
    xfer_count_t count_q, count_d;
    cpu_addr_t   addr_q, addr_d;
    cpu_data_t   wdata_q, wdata_d;
    dbg_byte_t   err_q, err_d;          // sticky, never cleared by a query
    logic        cyc_q, cyc_d;          // one wishbone transfer in flight
    logic        we_q, we_d;

    always_comb
    begin
        state_d   = state_q;
        exec_d    = exec_q;
        hdr_cnt_d = hdr_cnt_q;
        count_d   = count_q;
        addr_d    = addr_q;
        wdata_d   = wdata_q;
        err_d     = err_q;
        cyc_d     = cyc_q;
        we_d      = we_q;
        rx_pop    = 1'b0;
        tx_push   = 1'b0;
        tx_byte   = rx_byte;  // echo path

        case (state_q)
            st_disabled:
            begin
                if (brk)
                    state_d = st_decode;
                else if (!rx_empty)
                begin
                    if (rx_byte == op_query_dbg_brk)
                    begin
                        // hold the query until there is room for the answer
                        if (!tx_full)
                        begin
                            rx_pop  = 1'b1;
                            tx_push = 1'b1;
                            tx_byte = 8'h00;
                        end
                    end
                    else
                    begin
                        rx_pop = 1'b1;  // anything else is dropped
                        if (rx_byte == op_dbg_brk)
                            state_d = st_decode;
                    end
                end
            end

            st_decode:
            begin
                if (!rx_empty)
                begin
                    case (rx_byte)
                        op_echo:
                        begin
                            rx_pop    = 1'b1;
                            hdr_cnt_d = 2'd2;  // echo has no address
                            exec_d    = st_echo;
                            state_d   = st_header;
                        end
                        op_cpu_mem_rd:
                        begin
                            rx_pop    = 1'b1;
                            hdr_cnt_d = 2'd0;
                            exec_d    = st_read;
                            state_d   = st_header;
                        end
                        op_cpu_mem_wr:
                        begin
                            rx_pop    = 1'b1;
                            hdr_cnt_d = 2'd0;
                            exec_d    = st_write;
                            state_d   = st_header;
                        end
                        op_dbg_brk:
                            rx_pop = 1'b1;  // already in break
                        op_dbg_run:
                        begin
                            rx_pop  = 1'b1;
                            state_d = st_disabled;
                        end
                        op_query_dbg_brk:
                        begin
                            if (!tx_full)
                            begin
                                rx_pop  = 1'b1;
                                tx_push = 1'b1;
                                tx_byte = 8'h01;
                            end
                        end
                        op_query_err_code:
                        begin
                            if (!tx_full)
                            begin
                                rx_pop  = 1'b1;
                                tx_push = 1'b1;
                                tx_byte = err_q;
                            end
                        end
                        default:
                        begin
                            rx_pop                    = 1'b1;
                            err_d[err_unknown_opcode] = 1'b1;
                        end
                    endcase
                end
            end

            st_header:
            begin
                if (!rx_empty)
                begin
                    rx_pop    = 1'b1;
                    hdr_cnt_d = hdr_cnt_q + 2'd1;
                    case (hdr_cnt_q)
                        2'd0: addr_d  = {addr_q[15:8], rx_byte};
                        2'd1: addr_d  = {rx_byte, addr_q[7:0]};
                        2'd2: count_d = {count_q[15:8], rx_byte};
                        default:
                        begin
                            count_d = {rx_byte, count_q[7:0]};
                            state_d = (count_d == '0) ? st_decode : exec_q;
                        end
                    endcase
                end
            end

            st_echo:
            begin
                if (!rx_empty && !tx_full)
                begin
                    rx_pop  = 1'b1;
                    tx_push = 1'b1;
                    count_d = count_q - 16'd1;
                    if (count_q == 16'd1)
                        state_d = st_decode;
                end
            end

            st_write:
            begin
                if (cyc_q)
                begin
                    if (wb_ack)
                    begin
                        cyc_d   = 1'b0;
                        we_d    = 1'b0;
                        addr_d  = addr_q + 16'd1;  // wraps past ffff
                        count_d = count_q - 16'd1;
                        if (count_q == 16'd1)
                            state_d = st_decode;
                    end
                end
                else if (!rx_empty)
                begin
                    rx_pop  = 1'b1;  // next data byte only after the previous ack
                    wdata_d = rx_byte;
                    cyc_d   = 1'b1;
                    we_d    = 1'b1;
                end
            end

            st_read:
            begin
                if (cyc_q)
                begin
                    // tx_full was low at the start and only this engine pushes
                    if (wb_ack)
                    begin
                        tx_push = 1'b1;
                        tx_byte = wb_rdata;
                        cyc_d   = 1'b0;
                        addr_d  = addr_q + 16'd1;
                        count_d = count_q - 16'd1;
                        if (count_q == 16'd1)
                            state_d = st_decode;
                    end
                end
                else if (!tx_full)
                    cyc_d = 1'b1;
            end

            default:
                state_d = st_decode;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q   <= st_decode;  // comes up in break
            exec_q    <= st_echo;
            hdr_cnt_q <= 2'd0;
            count_q   <= '0;
            err_q     <= '0;
            cyc_q     <= 1'b0;
            we_q      <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            exec_q    <= exec_d;
            hdr_cnt_q <= hdr_cnt_d;
            count_q   <= count_d;
            err_q     <= err_d;
            cyc_q     <= cyc_d;
            we_q      <= we_d;
        end
    end

    always_ff @(posedge clk)
    begin
        addr_q  <= addr_d;
        wdata_q <= wdata_d;
    end

    assign active   = (state_q != st_disabled);
    assign wb_cyc   = cyc_q;
    assign wb_stb   = cyc_q;  // raised and dropped with cyc
    assign wb_we    = we_q;
    assign wb_adr   = addr_q;
    assign wb_wdata = wdata_q;

endmodule

`default_nettype wire

/* dbg_proto_pkg.sv */
`default_nettype none

// host debug protocol: byte type, opcodes and error code layout
package dbg_proto_pkg;

    // every packet and response is a stream of these
    typedef logic [7:0] dbg_byte_t;

    // first byte of each packet
    // values 05, 06 and 09 to 0c belonged to commands that are not served here,
    // so they fall into the unknown opcode path
    typedef enum dbg_byte_t {
        op_echo           = 8'h00, // cnt_lo, cnt_hi, data bytes
        op_cpu_mem_rd     = 8'h01, // addr_lo, addr_hi, cnt_lo, cnt_hi
        op_cpu_mem_wr     = 8'h02, // addr_lo, addr_hi, cnt_lo, cnt_hi, data bytes
        op_dbg_brk        = 8'h03,
        op_dbg_run        = 8'h04,
        op_query_dbg_brk  = 8'h07, // answers 01 in break, 00 while running
        op_query_err_code = 8'h08  // answers the sticky error byte
    } dbg_op_e;

    // bit positions inside the error code byte
    // bit 0 was the serial parity error and stays unused
    localparam int err_unknown_opcode = 1;

endpackage

`default_nettype wire

/* hci_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// handshake rules of the command engine on the bus and both fifos
module hci_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_we,
    input dbg_bus_pkg::cpu_addr_t wb_adr,
    input dbg_bus_pkg::cpu_data_t wb_wdata,
    input logic                   wb_ack,
    input logic                   tx_push,
    input logic                   tx_full,
    input logic                   rx_pop,
    input logic                   rx_empty
);

    int unsigned fail_cnt = 0;  // tally for the run summary

    stb_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else
    begin
        $error("wb_stb high outside a bus cycle");
        fail_cnt++;
    end

    // request held until the slave acks
    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata)))
    else
    begin
        $error("wishbone request changed before ack");
        fail_cnt++;
    end

    no_push_full: assert property (@(posedge clk) disable iff (rst) tx_full |-> !tx_push)
    else
    begin
        $error("push into a full tx fifo");
        fail_cnt++;
    end

    no_pop_empty: assert property (@(posedge clk) disable iff (rst) rx_empty |-> !rx_pop)
    else
    begin
        $error("pop from an empty rx fifo");
        fail_cnt++;
    end

endmodule

`default_nettype wire

/* hci_top.sv */
`timescale 1ns/10ps
`default_nettype none

// host command interface: rx fifo -> command engine -> tx fifo
module hci_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     brk,
    input  logic                     rx_push,
    input  dbg_proto_pkg::dbg_byte_t rx_byte,
    output logic                     rx_full,
    input  logic                     tx_pop,
    output dbg_proto_pkg::dbg_byte_t tx_byte,
    output logic                     tx_empty,
    output logic                     active,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output dbg_bus_pkg::cpu_addr_t   wb_adr,
    output dbg_bus_pkg::cpu_data_t   wb_wdata,
    input  dbg_bus_pkg::cpu_data_t   wb_rdata,
    input  logic                     wb_ack
);

    import dbg_proto_pkg::*;

    dbg_byte_t rx_head;   // oldest host byte
    logic      rx_empty;
    logic      rx_pop;
    dbg_byte_t tx_data;   // response byte from the engine
    logic      tx_push;
    logic      tx_full;

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .wdata (rx_byte),
        .pop   (rx_pop),
        .rdata (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

    dbg_cmd_engine engine (
        .clk      (clk),
        .rst      (rst),
        .brk      (brk),
        .rx_byte  (rx_head),
        .rx_empty (rx_empty),
        .rx_pop   (rx_pop),
        .tx_byte  (tx_data),
        .tx_full  (tx_full),
        .tx_push  (tx_push),
        .active   (active),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // responses to the host, in order of production
    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .wdata (tx_data),
        .pop   (tx_pop),
        .rdata (tx_byte),
        .full  (tx_full),
        .empty (tx_empty)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the hci testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hci -f sources.f -o sim_hci
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_hci +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
echo "no pass line in sim.log"
exit 1

/* sources.f */
dbg_proto_pkg.sv
dbg_bus_pkg.sv
byte_fifo.sv
dbg_cmd_engine.sv
hci_top.sv
hci_properties.sv
tb_hci.sv

/* tb_hci.sv */
`timescale 1ns/10ps
`default_nettype none

// testbench for the host command interface, byte level host and memory models
module tb_hci;

    import dbg_proto_pkg::*;
    import dbg_bus_pkg::*;

    localparam int tb_fifo_depth = 16;  // also sets the long tx stall

    logic      clk;
    logic      rst;
    logic      brk;
    logic      rx_push;
    dbg_byte_t rx_byte;
    logic      rx_full;
    logic      tx_pop;
    dbg_byte_t tx_byte;
    logic      tx_empty;
    logic      active;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    cpu_addr_t wb_adr;
    cpu_data_t wb_wdata;
    cpu_data_t wb_rdata;
    logic      wb_ack;

    logic [31:0] lfsr = 32'd83682;
    dbg_byte_t   push_q[$];        // host bytes not yet in the rx fifo
    dbg_byte_t   exp_q[$];         // responses still to come, oldest first
    cpu_data_t   sim_mem [65536];  // served by the bus model
    cpu_data_t   exp_mem [65536];
    bit          written [65536];
    dbg_byte_t   exp_err;
    logic        exp_active;
    logic        stall_en;
    int          stall_left;
    logic        slave_busy;
    logic [1:0]  ack_wait;
    int          cycle_cnt = 0;
    int          tot_bytes = 0;
    int          mismatch_cnt = 0;
    int          missing_cnt = 0;
    int          extra_cnt = 0;

    hci_top #(.FIFO_DEPTH(tb_fifo_depth)) DUT (.*);

    bind dbg_cmd_engine hci_properties props (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_ack   (wb_ack),
        .tx_push  (tx_push),
        .tx_full  (tx_full),
        .rx_pop   (rx_pop),
        .rx_empty (rx_empty)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit drawn
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xfer_count_t rand_count();
        return rand_bits(3) % 16'd7;  // 0 to 6
    endfunction

    function automatic cpu_addr_t rand_addr();
        if (rand_bits(1) == 16'd1)
            return 16'hffff - rand_bits(3);  // near the top so that counts wrap
        return rand_bits(16);
    endfunction

    function automatic cpu_data_t fill_byte(input cpu_addr_t a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
    endfunction

    function automatic int error_total();
        return mismatch_cnt + missing_cnt + extra_cnt + int'(DUT.engine.props.fail_cnt);
    endfunction

    task automatic check_byte(input dbg_byte_t got, input dbg_byte_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %02h, expected %02h", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_mem(input cpu_addr_t addr, input cpu_data_t got, input cpu_data_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: memory %04h holds %02h, expected %02h",
                     $time, addr, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d missing, %0d extra, %0d assertion failures",
                 mismatch_cnt, missing_cnt, extra_cnt, DUT.engine.props.fail_cnt);
    endtask

    task automatic send_byte(input dbg_byte_t b);
        push_q.push_back(b);
        tot_bytes++;
    endtask

    task automatic send_echo(input xfer_count_t cnt);
        dbg_byte_t d;
        send_byte(op_echo);
        send_byte(cnt[7:0]);
        send_byte(cnt[15:8]);
        for (int i = 0; i < int'(cnt); i++)
        begin
            d = 8'(rand_bits(8));
            send_byte(d);
            exp_q.push_back(d);
        end
    endtask

    // writes update the expected memory, reads expect it back in address order
    task automatic send_mem(input logic wr, input cpu_addr_t addr, input xfer_count_t cnt);
        cpu_addr_t a;
        cpu_data_t d;
        a = addr;
        send_byte(wr ? op_cpu_mem_wr : op_cpu_mem_rd);
        send_byte(addr[7:0]);
        send_byte(addr[15:8]);
        send_byte(cnt[7:0]);
        send_byte(cnt[15:8]);
        for (int i = 0; i < int'(cnt); i++)
        begin
            if (wr)
            begin
                d = 8'(rand_bits(8));
                send_byte(d);
                exp_mem[a] = d;
                written[a] = 1'b1;
            end
            else
                exp_q.push_back(exp_mem[a]);
            a = a + 16'd1;  // wraps past ffff
        end
    endtask

    task automatic send_query_brk();
        send_byte(op_query_dbg_brk);
        exp_q.push_back(exp_active ? 8'h01 : 8'h00);
    endtask

    task automatic send_query_err();
        send_byte(op_query_err_code);
        if (exp_active)
            exp_q.push_back(exp_err);  // dropped while running
    endtask

    task automatic send_unknown(input dbg_byte_t op);
        send_byte(op);
        if (exp_active)
            exp_err[err_unknown_opcode] = 1'b1;
    endtask

    task automatic send_run();
        send_byte(op_dbg_run);
        exp_active = 1'b0;
    endtask

    task automatic send_brk_op();
        send_byte(op_dbg_brk);
        exp_active = 1'b1;
    endtask

    // bytes a running engine must drop, so no break opcode and no break query
    task automatic send_ignored(input int n);
        dbg_byte_t b;
        for (int i = 0; i < n; i++)
        begin
            b = 8'(rand_bits(8));
            if (b == op_dbg_brk || b == op_query_dbg_brk)
                b = op_query_err_code;
            send_byte(b);
        end
    endtask

    task automatic random_command();
        cpu_addr_t a;
        xfer_count_t n;
        a = rand_addr();
        n = rand_count();
        case (rand_bits(3))
            16'd0: send_echo(n);
            16'd1: send_mem(1'b1, a, n);
            16'd2, 16'd3: send_mem(1'b0, a, n);
            16'd4: send_query_brk();
            16'd5: send_query_err();
            16'd6: send_unknown(8'h09 + 8'(rand_bits(4)));
            default: send_brk_op();  // no effect in decode
        endcase
    endtask

    task automatic pulse_brk();
        @(posedge clk);
        #1;
        brk = 1'b1;
        @(posedge clk);
        #1;
        brk = 1'b0;
        exp_active = 1'b1;
    endtask

    // every host byte taken and every expected response seen
    task automatic drain();
        while (push_q.size() != 0 || exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic host_push();
        if (push_q.size() != 0 && !rx_full)
        begin
            rx_byte = push_q.pop_front();
            rx_push = 1'b1;
        end
    endtask

    task automatic host_pop();
        if (stall_left != 0)
            stall_left--;
        else if (stall_en && rand_bits(4) == 16'd0)
            stall_left = 2 * tb_fifo_depth;  // long enough to fill the tx fifo
        else if (!tx_empty && !(stall_en && rand_bits(1) == 16'd1))
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected response byte %02h at %0t", tx_byte, $time);
                extra_cnt++;
            end
            else
                check_byte(tx_byte, exp_q.pop_front(), "response byte");
            tx_pop = 1'b1;
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles
    task automatic serve_bus();
        if (wb_ack)
            wb_ack = 1'b0;  // engine took the ack at this edge
        else if (wb_cyc && wb_stb)
        begin
            if (!slave_busy)
            begin
                slave_busy = 1'b1;
                ack_wait   = 2'(rand_bits(2));
            end
            if (ack_wait == 2'd0)
            begin
                slave_busy = 1'b0;
                wb_ack     = 1'b1;
                if (wb_we)
                    sim_mem[wb_adr] = wb_wdata;
                else
                    wb_rdata = sim_mem[wb_adr];
            end
            else
                ack_wait = ack_wait - 2'd1;
        end
    endtask

    // all dut inputs change 1 ns after the rising edge
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            cycle_cnt++;
            rx_push = 1'b0;
            tx_pop  = 1'b0;
            if (!rst)
            begin
                host_push();
                host_pop();
                serve_bus();
            end
        end
    end

    initial
    begin : watchdog
        while (cycle_cnt < 40 * tot_bytes + 200)
            @(negedge clk);
        missing_cnt = exp_q.size();
        $display("timeout after %0d cycles: %0d responses missing, %0d host bytes left",
                 cycle_cnt, exp_q.size(), push_q.size());
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin : main
        for (int a = 0; a < 65536; a++)
        begin
            sim_mem[a] = fill_byte(16'(a));
            exp_mem[a] = fill_byte(16'(a));
            written[a] = 1'b0;
        end
        rst        = 1'b1;
        brk        = 1'b0;
        rx_push    = 1'b0;
        rx_byte    = '0;
        tx_pop     = 1'b0;
        wb_rdata   = '0;
        wb_ack     = 1'b0;
        exp_err    = '0;
        exp_active = 1'b1;
        stall_en   = 1'b0;
        stall_left = 0;
        slave_busy = 1'b0;
        ack_wait   = 2'd0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag(active, 1'b1, "active after reset");

        send_query_err();  // clean error code
        send_query_brk();
        send_echo(16'd3);
        send_echo(16'd0);
        send_echo(rand_count());
        send_mem(1'b1, 16'hfffe, 16'd5);
        send_mem(1'b0, 16'hfffd, 16'd6);
        send_mem(1'b1, 16'h1234, 16'd0);
        send_mem(1'b1, 16'h4000, rand_count());
        send_mem(1'b0, 16'h4000, 16'd6);
        send_query_brk();
        drain();

        // run, then back to break by pin and by opcode
        send_run();
        send_ignored(6);
        send_query_brk();
        drain();
        check_flag(active, 1'b0, "active after run");
        pulse_brk();
        send_query_brk();
        drain();
        check_flag(active, 1'b1, "active after brk pulse");
        send_run();
        send_query_brk();
        send_brk_op();
        send_query_brk();
        drain();
        check_flag(active, 1'b1, "active after break opcode");

        send_unknown(8'h05);
        send_query_err();
        send_echo(16'd2);
        send_query_err();
        drain();

        // long mix under tx back-pressure
        stall_en = 1'b1;
        repeat (40) random_command();
        send_query_err();
        drain();
        stall_en   = 1'b0;
        stall_left = 0;  // host keeps popping so a stray byte shows up
        repeat (20) @(negedge clk);

        for (int a = 0; a < 65536; a++)
        begin
            if (written[a])
                check_mem(16'(a), sim_mem[a], exp_mem[a]);
        end
        print_counts();
        if (error_total() == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
